// File: testbench/rv_decode_stimulus.txt
# test cir vld err x_stall jump_now jump_from_decode jump_target (inputs, hex except test)
# expected: rs1 rs2 rd aluop memop branchcond except imm addr_offs use lock
1 00000000 0 0 0 0 0 00000000 00 00 00 0 0 0 0 00000000 00000000 0 0
1 00000000 0 0 0 0 0 00000000 00 00 00 0 0 0 0 00000000 00000000 0 0
2 00510093 1 0 0 0 0 00000000 02 00 01 0 0 0 0 00000005 00000005 1 0
2 002081b3 1 0 0 0 0 00000000 01 02 03 0 0 0 0 00000002 00000002 1 0
2 40118233 1 0 0 0 0 00000000 03 01 04 1 0 0 0 00000401 00000401 1 0
2 123452b7 1 0 0 0 0 00000000 00 00 05 a 0 0 0 12345000 00000123 1 0
2 fffff317 1 0 0 0 0 00000000 00 00 06 0 0 0 0 fffff000 ffffffff 1 0
2 ffc12383 1 0 0 0 0 00000000 02 00 07 0 3 0 0 fffffffc fffffffc 1 0
2 00712423 1 0 0 0 0 00000000 02 07 00 a 8 0 0 00000008 00000008 1 0
2 00208863 1 0 0 0 0 00000000 01 02 00 1 0 2 0 00000002 00000010 1 0
2 fe41ece3 1 0 0 0 0 00000000 03 04 00 4 0 3 0 ffffffe4 fffffff8 1 0
2 001000ef 1 0 0 0 0 00000000 00 00 01 0 0 1 0 00000004 00000800 1 0
2 00c08067 1 0 0 0 0 00000000 01 00 00 0 0 1 0 00000004 0000000c 1 0
3 ffffffff 1 0 0 0 0 00000000 00 00 00 0 0 0 3 ffffffff ffffffff 1 0
3 40209033 1 0 0 0 0 00000000 00 00 00 2 0 0 3 00000402 00000402 1 0
3 ffc12383 1 1 0 0 0 00000000 00 00 00 0 0 0 4 fffffffc fffffffc 1 0
3 00510093 0 1 0 0 0 00000000 00 00 00 0 0 0 0 00000005 00000005 0 0
4 00510093 1 0 1 0 0 00000000 02 00 01 0 0 0 0 00000005 00000005 0 0
4 00510093 1 0 1 0 0 00000000 02 00 01 0 0 0 0 00000005 00000005 0 0
4 00510093 1 0 0 1 0 00000100 02 00 01 0 0 0 0 00000005 00000005 1 0
4 002081b3 1 0 0 0 0 00000000 01 02 03 0 0 0 0 00000002 00000002 1 0
4 001000ef 1 0 0 1 1 00000200 00 00 01 0 0 1 0 00000004 00000800 1 0
5 001000ef 1 0 1 1 1 00000300 00 00 01 0 0 1 0 00000004 00000800 0 1
5 001000ef 1 0 1 0 0 00000300 00 00 01 0 0 0 0 00000004 00000800 0 1
5 001000ef 1 0 1 0 0 00000300 00 00 01 0 0 0 0 00000004 00000800 0 1
5 001000ef 1 0 0 0 0 00000300 00 00 01 0 0 0 0 00000004 00000800 1 0
5 00510093 1 0 0 0 0 00000000 02 00 01 0 0 0 0 00000005 00000005 1 0
6 00000073 1 0 0 0 0 00000000 00 00 00 0 0 0 1 00000000 00000000 1 0
6 00100073 1 0 0 0 0 00000000 00 00 00 0 0 0 2 00000001 00000001 1 0
6 0ff0000f 1 0 0 0 0 00000000 00 00 00 0 0 0 0 000000ff 000000ff 1 0
6 00000000 0 0 0 0 0 00000000 00 00 00 0 0 0 0 00000000 00000000 0 0

// File: rv_decode.f
src/rv_decode_pkg.sv
src/imm_sel_if.sv
src/cir_lock_fsm.sv
src/pc_counter.sv
src/imm_decode.sv
src/op_decode.sv
src/rv_decode.sv
testbench/tb_rv_decode.sv

// File: Bender.yml
package:
  name: rv_decode

sources:
  - src/rv_decode_pkg.sv
  - src/imm_sel_if.sv
  - src/cir_lock_fsm.sv
  - src/pc_counter.sv
  - src/imm_decode.sv
  - src/op_decode.sv
  - src/rv_decode.sv
  - target: test
    files:
      - testbench/tb_rv_decode.sv

// File: testbench/tb_rv_decode.sv
// Testbench for the decode stage driven and checked from a stimulus file, with PC model
`timescale 1ns/10ps
`default_nettype none

module tb_rv_decode;

	localparam int T_CLK        = 8;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_VEC      = 64;
	localparam int N_COL        = 19;
	localparam int MARGIN       = 16;

	// Stimulus file columns
	localparam int C_TEST  = 0;
	localparam int C_CIR   = 1;
	localparam int C_VLD   = 2;
	localparam int C_ERR   = 3;
	localparam int C_STALL = 4;
	localparam int C_JNOW  = 5;
	localparam int C_JDEC  = 6;
	localparam int C_JTGT  = 7;
	localparam int C_RS1   = 8;
	localparam int C_RS2   = 9;
	localparam int C_RD    = 10;
	localparam int C_ALUOP = 11;
	localparam int C_MEMOP = 12;
	localparam int C_BCOND = 13;
	localparam int C_EXC   = 14;
	localparam int C_IMM   = 15;
	localparam int C_OFFS  = 16;
	localparam int C_USE   = 17;
	localparam int C_LOCK  = 18;

	logic        clk;
	logic        rst_n;
	logic [31:0] cir;
	logic        cir_vld;
	logic        cir_err;
	logic        x_stall;
	logic        jump_now;
	logic        jump_from_decode;
	logic [31:0] jump_target;
	logic        cir_use;
	logic        cir_lock;
	logic        starved;
	logic [31:0] pc;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [31:0] imm;
	logic [31:0] addr_offs;
	logic        alusrc_a;
	logic        alusrc_b;
	logic [3:0]  aluop;
	logic [3:0]  memop;
	logic [1:0]  branchcond;
	logic        addr_is_regoffs;
	logic [2:0]  except_code;

	logic [31:0] vec [MAX_VEC][N_COL];
	int          num_vec;
	int          error_count;
	int          check_count;
	int          test_count;
	logic        vectors_loaded;
	logic [31:0] model_pc;
	logic        prev_lock;

	rv_decode i_rv_decode (
		.clk                (clk),
		.rst_n              (rst_n),
		.cir_i              (cir),
		.cir_vld_i          (cir_vld),
		.cir_err_i          (cir_err),
		.cir_use_o          (cir_use),
		.cir_lock_o         (cir_lock),
		.starved_o          (starved),
		.pc_o               (pc),
		.x_stall_i          (x_stall),
		.jump_now_i         (jump_now),
		.jump_from_decode_i (jump_from_decode),
		.jump_target_i      (jump_target),
		.rs1_o              (rs1),
		.rs2_o              (rs2),
		.rd_o               (rd),
		.imm_o              (imm),
		.addr_offs_o        (addr_offs),
		.alusrc_a_o         (alusrc_a),
		.alusrc_b_o         (alusrc_b),
		.aluop_o            (aluop),
		.memop_o            (memop),
		.branchcond_o       (branchcond),
		.addr_is_regoffs_o  (addr_is_regoffs),
		.except_o           (except_code)
	);

	initial begin
		clk = 1'b0;
		forever #(T_CLK / 2) clk = ~clk;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0d ns: %s expected %h actual %h", $time, name,
				expected, actual);
		end
	endtask

	// Operand sources and address base by instruction class
	// Bits are alusrc_a (PC), alusrc_b (IMM) and addr_is_regoffs
	function automatic logic [2:0] expected_sources(input logic [31:0] word);
		logic [2:0] src;
		case (word[6:0])
			rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_AUIPC:  src = 3'b110;
			rv_decode_pkg::OPC_JALR:                           src = 3'b111;
			rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_OP_IMM: src = 3'b010;
			rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_STORE: src = 3'b001;
			default:                                           src = 3'b000;
		endcase
		return src;
	endfunction

	// Comment lines start with #, data lines hold N_COL fields
	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [N_COL];
		fd = $fopen("testbench/rv_decode_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file testbench/rv_decode_stimulus.txt");
		end else begin
			while ($fgets(line, fd) != 0 && num_vec < MAX_VEC) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
						f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
					if (n == N_COL) begin
						for (int c = 0; c < N_COL; c++) begin
							vec[num_vec][c] = f[c];
						end
						num_vec++;
					end else begin
						error_count++;
						$display("stimulus line could not be parsed: %s", line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_vector(input int k);
		cir              <= vec[k][C_CIR];
		cir_vld          <= vec[k][C_VLD][0];
		cir_err          <= vec[k][C_ERR][0];
		x_stall          <= vec[k][C_STALL][0];
		jump_now         <= vec[k][C_JNOW][0];
		jump_from_decode <= vec[k][C_JDEC][0];
		jump_target      <= vec[k][C_JTGT];
	endtask

	task automatic check_vector(input int k);
		logic       exp_starved;
		logic [2:0] exp_src;
		exp_starved = !vec[k][C_VLD][0];
		exp_src     = expected_sources(vec[k][C_CIR]);
		check_value("starved_o", exp_starved, starved);
		check_value("pc_o", model_pc, pc);
		check_value("rs1_o", vec[k][C_RS1], rs1);
		check_value("rs2_o", vec[k][C_RS2], rs2);
		check_value("rd_o", vec[k][C_RD], rd);
		check_value("aluop_o", vec[k][C_ALUOP], aluop);
		check_value("memop_o", vec[k][C_MEMOP], memop);
		check_value("branchcond_o", vec[k][C_BCOND], branchcond);
		check_value("except_o", vec[k][C_EXC], except_code);
		check_value("imm_o", vec[k][C_IMM], imm);
		check_value("addr_offs_o", vec[k][C_OFFS], addr_offs);
		check_value("alusrc_a_o", exp_src[2], alusrc_a);
		check_value("alusrc_b_o", exp_src[1], alusrc_b);
		check_value("addr_is_regoffs_o", exp_src[0], addr_is_regoffs);
		check_value("cir_use_o", vec[k][C_USE], cir_use);
		check_value("cir_lock_o", vec[k][C_LOCK], cir_lock);
	endtask

	// PC after the edge that closes cycle k, jump before advance
	task automatic update_pc_model(input int k);
		logic stalled;
		logic lock_request;
		logic load;
		stalled      = vec[k][C_STALL][0] || !vec[k][C_VLD][0];
		lock_request = vec[k][C_JNOW][0] && vec[k][C_JDEC][0] && stalled;
		load = (vec[k][C_JNOW][0] && !lock_request) || (prev_lock && !vec[k][C_LOCK][0]);
		if (load) begin
			model_pc = vec[k][C_JTGT];
		end else if (vec[k][C_USE][0]) begin
			model_pc = model_pc + 32'd4;
		end
		prev_lock = vec[k][C_LOCK][0];
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin : main
		int start_errors;
		int start_checks;
		rst_n            = 1'b0;
		cir              = '0;
		cir_vld          = 1'b0;
		cir_err          = 1'b0;
		x_stall          = 1'b0;
		jump_now         = 1'b0;
		jump_from_decode = 1'b0;
		jump_target      = '0;
		num_vec          = 0;
		error_count      = 0;
		check_count      = 0;
		test_count       = 0;
		vectors_loaded   = 1'b0;
		model_pc         = rv_decode_pkg::RESET_VECTOR;
		prev_lock        = 1'b0;
		load_vectors();
		vectors_loaded = 1'b1;
		if (num_vec == 0) begin
			$display("no stimulus vectors were read");
			$display("sim failed");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(posedge clk);
			rst_n <= 1'b1;
			start_errors = error_count;
			start_checks = check_count;
			for (int k = 0; k < num_vec; k++) begin
				@(posedge clk);
				apply_vector(k);
				#(T_CLK - 1);
				check_vector(k);
				update_pc_model(k);
				if (k == num_vec - 1 || vec[k + 1][C_TEST] != vec[k][C_TEST]) begin
					test_count++;
					$display("test %0d done: %0d checks, %0d errors", vec[k][C_TEST],
						check_count - start_checks, error_count - start_errors);
					start_errors = error_count;
					start_checks = check_count;
				end
			end
			$display("%0d tests, %0d checks, %0d errors", test_count, check_count,
				error_count);
			if (error_count == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	end

	initial begin : watchdog
		wait (vectors_loaded === 1'b1);
		#((num_vec + RESET_CYCLES + MARGIN) * T_CLK);
		$display("timeout: the run did not end within %0d clock cycles",
			num_vec + RESET_CYCLES + MARGIN);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/rv_decode.sv
// Decode stage top level with lock FSM, PC counter, opcode decoder and immediate unit
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
	input  wire                                    clk,
	input  wire                                    rst_n,

	// Fetch handshake
	input  wire  [rv_decode_pkg::W_DATA-1:0]       cir_i,
	input  wire                                    cir_vld_i,
	input  wire                                    cir_err_i,
	output logic                                   cir_use_o,
	output logic                                   cir_lock_o,
	output logic                                   starved_o,
	output logic [rv_decode_pkg::W_ADDR-1:0]       pc_o,

	// Execute stall and jump request
	input  wire                                    x_stall_i,
	input  wire                                    jump_now_i,
	input  wire                                    jump_from_decode_i,
	input  wire  [rv_decode_pkg::W_ADDR-1:0]       jump_target_i,

	// Execute controls
	output logic [rv_decode_pkg::W_REGADDR-1:0]    rs1_o,
	output logic [rv_decode_pkg::W_REGADDR-1:0]    rs2_o,
	output logic [rv_decode_pkg::W_REGADDR-1:0]    rd_o,
	output logic [rv_decode_pkg::W_DATA-1:0]       imm_o,
	output logic [rv_decode_pkg::W_ADDR-1:0]       addr_offs_o,
	output rv_decode_pkg::alusrc_a_t               alusrc_a_o,
	output rv_decode_pkg::alusrc_b_t               alusrc_b_o,
	output rv_decode_pkg::aluop_t                  aluop_o,
	output rv_decode_pkg::memop_t                  memop_o,
	output rv_decode_pkg::bcond_t                  branchcond_o,
	output logic                                   addr_is_regoffs_o,
	output rv_decode_pkg::except_t                 except_o
);

	rv_decode_pkg::instr_t cir_word;
	logic                  lock_held;
	logic                  pc_load;
	logic                  pc_advance;

	imm_sel_if imm_sel ();

	assign cir_word = rv_decode_pkg::instr_t'(cir_i);

	cir_lock_fsm i_cir_lock_fsm (
		.clk                (clk),
		.rst_n              (rst_n),
		.cir_vld_i          (cir_vld_i),
		.x_stall_i          (x_stall_i),
		.jump_now_i         (jump_now_i),
		.jump_from_decode_i (jump_from_decode_i),
		.starved_o          (starved_o),
		.cir_use_o          (cir_use_o),
		.cir_lock_o         (cir_lock_o),
		.lock_held_o        (lock_held),
		.pc_load_o          (pc_load),
		.pc_advance_o       (pc_advance)
	);

	pc_counter i_pc_counter (
		.clk           (clk),
		.rst_n         (rst_n),
		.pc_load_i     (pc_load),
		.pc_advance_i  (pc_advance),
		.jump_target_i (jump_target_i),
		.pc_o          (pc_o)
	);

	op_decode i_op_decode (
		.instr_i           (cir_word),
		.starved_i         (starved_o),
		.cir_err_i         (cir_err_i),
		.lock_held_i       (lock_held),
		.imm               (imm_sel.dec),
		.rs1_o             (rs1_o),
		.rs2_o             (rs2_o),
		.rd_o              (rd_o),
		.alusrc_a_o        (alusrc_a_o),
		.alusrc_b_o        (alusrc_b_o),
		.aluop_o           (aluop_o),
		.memop_o           (memop_o),
		.branchcond_o      (branchcond_o),
		.addr_is_regoffs_o (addr_is_regoffs_o),
		.except_o          (except_o)
	);

	imm_decode i_imm_decode (
		.instr_i (cir_word),
		.imm     (imm_sel.gen)
	);

	assign imm_o       = imm_sel.imm;
	assign addr_offs_o = imm_sel.addr_offs;

endmodule

`default_nettype wire

// File: src/op_decode.sv
// RV32I opcode decoder with execute controls, illegal detection and squash
`timescale 1ns/10ps
`default_nettype none

module op_decode (
	input  wire rv_decode_pkg::instr_t            instr_i,
	input  wire                                   starved_i,
	input  wire                                   cir_err_i,
	input  wire                                   lock_held_i,
	imm_sel_if.dec                                imm,
	output logic [rv_decode_pkg::W_REGADDR-1:0]   rs1_o,
	output logic [rv_decode_pkg::W_REGADDR-1:0]   rs2_o,
	output logic [rv_decode_pkg::W_REGADDR-1:0]   rd_o,
	output rv_decode_pkg::alusrc_a_t              alusrc_a_o,
	output rv_decode_pkg::alusrc_b_t              alusrc_b_o,
	output rv_decode_pkg::aluop_t                 aluop_o,
	output rv_decode_pkg::memop_t                 memop_o,
	output rv_decode_pkg::bcond_t                 branchcond_o,
	output logic                                  addr_is_regoffs_o,
	output rv_decode_pkg::except_t                except_o
);

	logic invalid;
	logic fault;

	// Shared by OP and OP_IMM, alt selects SUB/SRA
	function automatic rv_decode_pkg::aluop_t f3_aluop(input logic [2:0] f3, input logic alt);
		rv_decode_pkg::aluop_t op;
		case (f3)
			3'b000:  op = alt ? rv_decode_pkg::ALUOP_SUB : rv_decode_pkg::ALUOP_ADD;
			3'b001:  op = rv_decode_pkg::ALUOP_SLL;
			3'b010:  op = rv_decode_pkg::ALUOP_LT;
			3'b011:  op = rv_decode_pkg::ALUOP_LTU;
			3'b100:  op = rv_decode_pkg::ALUOP_XOR;
			3'b101:  op = alt ? rv_decode_pkg::ALUOP_SRA : rv_decode_pkg::ALUOP_SRL;
			3'b110:  op = rv_decode_pkg::ALUOP_OR;
			default: op = rv_decode_pkg::ALUOP_AND;
		endcase
		return op;
	endfunction

	// Only a word that is actually there can carry a bus fault
	assign fault = !starved_i && cir_err_i;

	always_comb begin
		rs1_o             = instr_i.r.rs1;
		rs2_o             = instr_i.r.rs2;
		rd_o              = instr_i.r.rd;
		imm.imm_kind      = rv_decode_pkg::IMM_I;
		imm.offs_kind     = rv_decode_pkg::OFFS_I;
		alusrc_a_o        = rv_decode_pkg::ALUSRCA_RS1;
		alusrc_b_o        = rv_decode_pkg::ALUSRCB_RS2;
		aluop_o           = rv_decode_pkg::ALUOP_ADD;
		memop_o           = rv_decode_pkg::MEMOP_NONE;
		branchcond_o      = rv_decode_pkg::BCOND_NEVER;
		addr_is_regoffs_o = 1'b0;
		except_o          = rv_decode_pkg::EXCEPT_NONE;
		invalid           = 1'b0;

		case (instr_i.r.opcode)
			rv_decode_pkg::OPC_BRANCH: begin
				rd_o          = rv_decode_pkg::X0;
				imm.offs_kind = rv_decode_pkg::OFFS_B;
				case (instr_i.r.funct3[2:1])
					2'b00:   aluop_o = rv_decode_pkg::ALUOP_SUB;
					2'b10:   aluop_o = rv_decode_pkg::ALUOP_LT;
					2'b11:   aluop_o = rv_decode_pkg::ALUOP_LTU;
					default: invalid = 1'b1;
				endcase
				// BNE, BLT and BLTU take the branch on a nonzero result
				branchcond_o = instr_i.r.funct3[0] ^ instr_i.r.funct3[2] ?
					rv_decode_pkg::BCOND_NZERO : rv_decode_pkg::BCOND_ZERO;
			end
			rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR: begin
				rs2_o        = rv_decode_pkg::X0;
				branchcond_o = rv_decode_pkg::BCOND_ALWAYS;
				alusrc_a_o   = rv_decode_pkg::ALUSRCA_PC;
				alusrc_b_o   = rv_decode_pkg::ALUSRCB_IMM;
				imm.imm_kind = rv_decode_pkg::IMM_LINK;
				if (instr_i.r.opcode == rv_decode_pkg::OPC_JAL) begin
					rs1_o         = rv_decode_pkg::X0;
					imm.offs_kind = rv_decode_pkg::OFFS_J;
				end else begin
					addr_is_regoffs_o = 1'b1;
					invalid           = instr_i.r.funct3 != 3'b000;
				end
			end
			rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: begin
				rs1_o        = rv_decode_pkg::X0;
				rs2_o        = rv_decode_pkg::X0;
				imm.imm_kind = rv_decode_pkg::IMM_U;
				alusrc_b_o   = rv_decode_pkg::ALUSRCB_IMM;
				if (instr_i.r.opcode == rv_decode_pkg::OPC_LUI) begin
					aluop_o = rv_decode_pkg::ALUOP_RS2;
				end else begin
					alusrc_a_o = rv_decode_pkg::ALUSRCA_PC;
				end
			end
			rv_decode_pkg::OPC_OP_IMM: begin
				rs2_o      = rv_decode_pkg::X0;
				alusrc_b_o = rv_decode_pkg::ALUSRCB_IMM;
				aluop_o    = f3_aluop(instr_i.r.funct3,
					instr_i.r.funct3 == 3'b101 && instr_i.r.funct7[5]);
				// Shift amounts leave only funct7 to check
				if (instr_i.r.funct3 == 3'b001) begin
					invalid = instr_i.r.funct7 != rv_decode_pkg::F7_BASE;
				end else if (instr_i.r.funct3 == 3'b101) begin
					invalid = instr_i.r.funct7 != rv_decode_pkg::F7_BASE &&
						instr_i.r.funct7 != rv_decode_pkg::F7_ALT;
				end
			end
			rv_decode_pkg::OPC_OP: begin
				aluop_o = f3_aluop(instr_i.r.funct3, instr_i.r.funct7[5]);
				invalid = !(instr_i.r.funct7 == rv_decode_pkg::F7_BASE ||
					instr_i.r.funct7 == rv_decode_pkg::F7_ALT &&
					(instr_i.r.funct3 == 3'b000 || instr_i.r.funct3 == 3'b101));
			end
			rv_decode_pkg::OPC_LOAD: begin
				rs2_o             = rv_decode_pkg::X0;
				addr_is_regoffs_o = 1'b1;
				case (instr_i.r.funct3)
					3'b000:  memop_o = rv_decode_pkg::MEMOP_LB;
					3'b001:  memop_o = rv_decode_pkg::MEMOP_LH;
					3'b010:  memop_o = rv_decode_pkg::MEMOP_LW;
					3'b100:  memop_o = rv_decode_pkg::MEMOP_LBU;
					3'b101:  memop_o = rv_decode_pkg::MEMOP_LHU;
					default: invalid = 1'b1;
				endcase
			end
			rv_decode_pkg::OPC_STORE: begin
				// Store data passes through the ALU from rs2
				rd_o              = rv_decode_pkg::X0;
				aluop_o           = rv_decode_pkg::ALUOP_RS2;
				addr_is_regoffs_o = 1'b1;
				imm.imm_kind      = rv_decode_pkg::IMM_S;
				imm.offs_kind     = rv_decode_pkg::OFFS_S;
				case (instr_i.r.funct3)
					3'b000:  memop_o = rv_decode_pkg::MEMOP_SB;
					3'b001:  memop_o = rv_decode_pkg::MEMOP_SH;
					3'b010:  memop_o = rv_decode_pkg::MEMOP_SW;
					default: invalid = 1'b1;
				endcase
			end
			rv_decode_pkg::OPC_MISC_MEM: begin
				// FENCE is a no-op on a single in-order hart
				rs1_o   = rv_decode_pkg::X0;
				rs2_o   = rv_decode_pkg::X0;
				rd_o    = rv_decode_pkg::X0;
				invalid = instr_i.r.funct3 != 3'b000;
			end
			rv_decode_pkg::OPC_SYSTEM: begin
				rs1_o = rv_decode_pkg::X0;
				rs2_o = rv_decode_pkg::X0;
				rd_o  = rv_decode_pkg::X0;
				if (instr_i.i.rs1 != rv_decode_pkg::X0 || instr_i.i.funct3 != 3'b000 ||
					instr_i.i.rd != rv_decode_pkg::X0) begin
					invalid = 1'b1;
				end else if (instr_i.i.imm12 == rv_decode_pkg::SYS_ECALL) begin
					except_o = rv_decode_pkg::EXCEPT_ECALL;
				end else if (instr_i.i.imm12 == rv_decode_pkg::SYS_EBREAK) begin
					except_o = rv_decode_pkg::EXCEPT_EBREAK;
				end else begin
					invalid = 1'b1;
				end
			end
			default: begin
				invalid = 1'b1;
			end
		endcase

		// ----------------------------------------
		// Squash anything with no side effects allowed
		// ----------------------------------------
		if (invalid || starved_i || fault) begin
			rs1_o        = rv_decode_pkg::X0;
			rs2_o        = rv_decode_pkg::X0;
			rd_o         = rv_decode_pkg::X0;
			memop_o      = rv_decode_pkg::MEMOP_NONE;
			branchcond_o = rv_decode_pkg::BCOND_NEVER;
			except_o     = rv_decode_pkg::EXCEPT_NONE;
			if (fault) begin
				except_o = rv_decode_pkg::EXCEPT_INSTR_FAULT;
			end else if (invalid && !starved_i) begin
				except_o = rv_decode_pkg::EXCEPT_INSTR_ILLEGAL;
			end
		end

		// Jump already issued for the locked instruction
		if (lock_held_i) begin
			branchcond_o = rv_decode_pkg::BCOND_NEVER;
		end
	end

endmodule

`default_nettype wire

// File: src/imm_decode.sv
// Immediate formats and selection of the immediate and the address offset
`timescale 1ns/10ps
`default_nettype none

module imm_decode (
	input  wire rv_decode_pkg::instr_t instr_i,
	imm_sel_if.gen                     imm
);

	logic [rv_decode_pkg::W_DATA-1:0] imm_i;
	logic [rv_decode_pkg::W_DATA-1:0] imm_s;
	logic [rv_decode_pkg::W_DATA-1:0] imm_b;
	logic [rv_decode_pkg::W_DATA-1:0] imm_u;
	logic [rv_decode_pkg::W_DATA-1:0] imm_j;

	// Sign bit is always instr[31], the top bit of imm12
	assign imm_i = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
	assign imm_s = {{20{instr_i.r.funct7[6]}}, instr_i.r.funct7, instr_i.r.rd};
	assign imm_b = {{20{instr_i.r.funct7[6]}}, instr_i.r.rd[0], instr_i.r.funct7[5:0],
		instr_i.r.rd[4:1], 1'b0};
	assign imm_u = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'h000};
	assign imm_j = {{12{instr_i.i.imm12[11]}}, instr_i.i.rs1, instr_i.i.funct3,
		instr_i.i.imm12[0], instr_i.i.imm12[10:1], 1'b0};

	always_comb begin
		case (imm.imm_kind)
			rv_decode_pkg::IMM_S:    imm.imm = imm_s;
			rv_decode_pkg::IMM_U:    imm.imm = imm_u;
			// Link address offset for JAL and JALR
			rv_decode_pkg::IMM_LINK: imm.imm = rv_decode_pkg::INSTR_BYTES;
			default:                 imm.imm = imm_i;
		endcase
	end

	always_comb begin
		case (imm.offs_kind)
			rv_decode_pkg::OFFS_S: imm.addr_offs = imm_s;
			rv_decode_pkg::OFFS_B: imm.addr_offs = imm_b;
			rv_decode_pkg::OFFS_J: imm.addr_offs = imm_j;
			default:               imm.addr_offs = imm_i;
		endcase
	end

endmodule

`default_nettype wire

// File: src/pc_counter.sv
// Decode program counter with reset vector, jump load and advance
`timescale 1ns/10ps
`default_nettype none

module pc_counter (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire                              pc_load_i,
	input  wire                              pc_advance_i,
	input  wire  [rv_decode_pkg::W_ADDR-1:0] jump_target_i,
	output logic [rv_decode_pkg::W_ADDR-1:0] pc_o
);

	logic [rv_decode_pkg::W_ADDR-1:0] pc_q;

	// Jump has priority over the sequential step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= rv_decode_pkg::RESET_VECTOR;
		end else if (pc_load_i) begin
			pc_q <= jump_target_i;
		end else if (pc_advance_i) begin
			pc_q <= pc_q + rv_decode_pkg::INSTR_BYTES;
		end
	end

	assign pc_o = pc_q;

	// No compressed support, so every PC is a word address
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		pc_o[1:0] == 2'b00
	) else $error("Decode PC not word aligned: %h", pc_o);

endmodule

`default_nettype wire

// File: src/cir_lock_fsm.sv
// Starvation, stall, instruction use, CIR lock state machine and PC update strobes
`timescale 1ns/10ps
`default_nettype none

module cir_lock_fsm (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  cir_vld_i,
	input  wire  x_stall_i,
	input  wire  jump_now_i,
	input  wire  jump_from_decode_i,
	output logic starved_o,
	output logic cir_use_o,
	output logic cir_lock_o,
	output logic lock_held_o,
	output logic pc_load_o,
	output logic pc_advance_o
);

	logic state_q;
	logic stall;
	logic assert_lock;

	assign starved_o = !cir_vld_i;
	assign stall     = x_stall_i || starved_o;
	assign cir_use_o = !stall;

	// A jump from the instruction in decode must not lose the CIR while
	// execute holds us, or the link and other side effects are trashed
	assign assert_lock = jump_now_i && jump_from_decode_i && stall;
	assign lock_held_o = state_q == rv_decode_pkg::ST_LOCKED;
	assign cir_lock_o  = (lock_held_o && stall) || assert_lock;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= rv_decode_pkg::ST_IDLE;
		end else begin
			state_q <= cir_lock_o ? rv_decode_pkg::ST_LOCKED : rv_decode_pkg::ST_IDLE;
		end
	end

	// ----------------------------------------
	// PC strobes
	// ----------------------------------------

	// Target was presented earlier, load it when the lock lets go
	assign pc_load_o    = (jump_now_i && !assert_lock) || (lock_held_o && !stall);
	assign pc_advance_o = cir_use_o;

	// A jump raised by decode needs a word in decode
	a_decode_jump_has_word: assert property (
		@(posedge clk) disable iff (!rst_n)
		jump_now_i && jump_from_decode_i |-> cir_vld_i
	) else $error("Jump from decode without a valid CIR word");

endmodule

`default_nettype wire

// File: src/imm_sel_if.sv
// Immediate and offset selection interface between opcode decoder and immediate unit
`timescale 1ns/10ps
`default_nettype none

interface imm_sel_if;

	// Selections from the opcode decoder
	rv_decode_pkg::imm_kind_t             imm_kind;
	rv_decode_pkg::offs_kind_t            offs_kind;

	// Results from the immediate unit
	logic [rv_decode_pkg::W_DATA-1:0]     imm;
	logic [rv_decode_pkg::W_ADDR-1:0]     addr_offs;

	modport dec (
		output imm_kind,
		output offs_kind
	);

	modport gen (
		input  imm_kind,
		input  offs_kind,
		output imm,
		output addr_offs
	);

endinterface

`default_nettype wire

// File: src/rv_decode_pkg.sv
// Widths, reset vector, opcodes, decode encodings and the instruction word type
`default_nettype none

package rv_decode_pkg;

	// ----------------------------------------
	// Widths and constants
	// ----------------------------------------

	localparam int W_DATA    = 32;
	localparam int W_ADDR    = 32;
	localparam int W_REGADDR = 5;

	localparam logic [W_ADDR-1:0]    RESET_VECTOR = 32'h0000_0040;
	localparam logic [W_DATA-1:0]    INSTR_BYTES  = 32'd4;
	localparam logic [W_REGADDR-1:0] X0           = '0;

	// Lock state encoding
	localparam logic ST_IDLE   = 1'b0;
	localparam logic ST_LOCKED = 1'b1;

	// ----------------------------------------
	// Major opcodes
	// ----------------------------------------

	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	// funct7 for plain and alternate (SUB, SRA) forms
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// imm12 field of the SYSTEM instructions we keep
	localparam logic [11:0] SYS_ECALL  = 12'h000;
	localparam logic [11:0] SYS_EBREAK = 12'h001;

	// ----------------------------------------
	// Execute controls
	// ----------------------------------------

	typedef enum logic [3:0] {
		ALUOP_ADD = 4'h0,
		ALUOP_SUB = 4'h1,
		ALUOP_SLL = 4'h2,
		ALUOP_LT  = 4'h3,
		ALUOP_LTU = 4'h4,
		ALUOP_XOR = 4'h5,
		ALUOP_SRL = 4'h6,
		ALUOP_SRA = 4'h7,
		ALUOP_OR  = 4'h8,
		ALUOP_AND = 4'h9,
		ALUOP_RS2 = 4'ha
	} aluop_t;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alusrc_a_t;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alusrc_b_t;

	typedef enum logic [3:0] {
		MEMOP_NONE = 4'h0,
		MEMOP_LB   = 4'h1,
		MEMOP_LH   = 4'h2,
		MEMOP_LW   = 4'h3,
		MEMOP_LBU  = 4'h4,
		MEMOP_LHU  = 4'h5,
		MEMOP_SB   = 4'h6,
		MEMOP_SH   = 4'h7,
		MEMOP_SW   = 4'h8
	} memop_t;

	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ALWAYS, BCOND_ZERO, BCOND_NZERO} bcond_t;

	typedef enum logic [2:0] {
		EXCEPT_NONE          = 3'd0,
		EXCEPT_ECALL         = 3'd1,
		EXCEPT_EBREAK        = 3'd2,
		EXCEPT_INSTR_ILLEGAL = 3'd3,
		EXCEPT_INSTR_FAULT   = 3'd4
	} except_t;

	// Immediate and address offset selectors
	typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_LINK} imm_kind_t;
	typedef enum logic [1:0] {OFFS_I, OFFS_S, OFFS_B, OFFS_J} offs_kind_t;

	// ----------------------------------------
	// Instruction word, register view and immediate view
	// ----------------------------------------

	typedef union packed {
		struct packed {
			logic [6:0]           funct7;
			logic [W_REGADDR-1:0] rs2;
			logic [W_REGADDR-1:0] rs1;
			logic [2:0]           funct3;
			logic [W_REGADDR-1:0] rd;
			logic [6:0]           opcode;
		} r;
		struct packed {
			logic [11:0]          imm12;
			logic [W_REGADDR-1:0] rs1;
			logic [2:0]           funct3;
			logic [W_REGADDR-1:0] rd;
			logic [6:0]           opcode;
		} i;
	} instr_t;

endpackage

`default_nettype wire
